// ==== all.f ====
+incdir+verilog
verilog/pinmux_pkg.sv
verilog/reg_bus_if.sv
verilog/reg_bus_front.sv
verilog/risc_cfg_regs.sv
verilog/gpio_cfg_regs.sv
verilog/gpio_intr_ctrl.sv
verilog/pinmux_reg.sv
sim/tb_pinmux_reg.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pinmux_reg
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: run clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_pinmux_reg.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

module tb_pinmux_reg import pinmux_pkg::*;;

   localparam int ACK_TIMEOUT = 20;              // Edges allowed before ack

   // Writable registers, in test order
   localparam logic [4:0] WR_IDX [9] = '{`PINMUX_R_FUSE, `PINMUX_R_GPIO_OUT,
      `PINMUX_R_GPIO_DIR, `PINMUX_R_GPIO_TYPE, `PINMUX_R_IRQ, `PINMUX_R_PULSE,
      `PINMUX_R_INT_MASK, `PINMUX_R_POSEDGE, `PINMUX_R_NEGEDGE};

   logic                       mclk;
   logic                       h_reset_n;
   logic                       reg_cs;
   logic                       reg_wr;
   logic [`PINMUX_AW-1:0]      reg_addr;
   reg_word_t                  reg_wdata;
   logic [`PINMUX_BE_W-1:0]    reg_be;
   reg_word_t                  reg_rdata;
   logic                       reg_ack;
   logic [1:0]                 ext_intr_in;
   reg_word_t                  fuse_mhartid;
   logic [`PINMUX_IRQ_W-1:0]   irq_lines;
   logic [2:0]                 user_irq;
   logic [`PINMUX_PULSE_W-1:0] cfg_pulse_1us;
   reg_word_t                  gpio_in_data;
   reg_word_t                  gpio_int_event;
   reg_word_t                  cfg_gpio_out_data;
   reg_word_t                  cfg_gpio_data_in;
   reg_word_t                  cfg_gpio_dir_sel;
   reg_word_t                  cfg_gpio_out_type;
   reg_word_t                  cfg_gpio_posedge_int_sel;
   reg_word_t                  cfg_gpio_negedge_int_sel;
   reg_word_t                  gpio_prev_indata;

   int        err_cnt;
   int        tmo_cnt;
   integer    seed;
   reg_word_t shadow [0:31];    // Expected register contents
   reg_word_t stat;             // Expected interrupt status
   chip_id_t  exp_id;

   pinmux_reg UUT (.*);         // Port names match one to one

   initial
   begin
      mclk = 1'b0;
      forever #5 mclk = ~mclk;  // 100 MHz
   end

   //----------------------------------------
   // Checking helpers
   //----------------------------------------
   task automatic check_val(input string name, input reg_word_t got, input reg_word_t exp);
      assert (got === exp)
      else
      begin
         err_cnt++;
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Byte lanes selected by the enables
   function automatic reg_word_t lane_mask(input logic [3:0] be);
      reg_word_t m;
      m = '0;
      for (int i = 0; i < 4; i++)
      begin
         if (be[i])
            m[i*8 +: 8] = 8'hff;
      end
      return m;
   endfunction

   // Bits a register really keeps
   function automatic reg_word_t width_mask(input logic [4:0] idx);
      if (idx == `PINMUX_R_IRQ)
         return 32'h0000_ffff;                   // 16 IRQ lines
      else if (idx == `PINMUX_R_PULSE)
         return 32'h0000_03ff;                   // 10-bit divider
      else
         return 32'hffff_ffff;
   endfunction

   task automatic check_cfg(input logic [4:0] idx, input reg_word_t exp);
      case (idx)
         `PINMUX_R_FUSE      : check_val("fuse_mhartid", fuse_mhartid, exp);
         `PINMUX_R_IRQ       : check_val("irq_lines", {16'h0, irq_lines}, exp);
         `PINMUX_R_PULSE     : check_val("cfg_pulse_1us", {22'h0, cfg_pulse_1us}, exp);
         `PINMUX_R_GPIO_OUT  : check_val("cfg_gpio_out_data", cfg_gpio_out_data, exp);
         `PINMUX_R_GPIO_DIR  : check_val("cfg_gpio_dir_sel", cfg_gpio_dir_sel, exp);
         `PINMUX_R_GPIO_TYPE : check_val("cfg_gpio_out_type", cfg_gpio_out_type, exp);
         `PINMUX_R_POSEDGE   : check_val("cfg_gpio_posedge_int_sel",
                                         cfg_gpio_posedge_int_sel, exp);
         `PINMUX_R_NEGEDGE   : check_val("cfg_gpio_negedge_int_sel",
                                         cfg_gpio_negedge_int_sel, exp);
         default             : ;                 // Mask has no output pin
      endcase
   endtask

   //----------------------------------------
   // Register bus master
   //----------------------------------------
   task automatic bus_xfer(input logic wr, input logic [4:0] idx, input reg_word_t wd,
                           input logic [3:0] be, output reg_word_t data);
      int n;
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = {1'b0, idx, 2'b00};            // Word aligned
      reg_wdata = wd;
      reg_be    = be;
      n = 0;
      do
      begin
         @(posedge mclk);
         #1;
         n++;
      end
      while (!reg_ack && n < ACK_TIMEOUT);
      if (!reg_ack)
      begin
         tmo_cnt++;
         $display("Timeout: no acknowledge for index %0d after %0d cycles", idx, n);
      end
      else
         check_val("reg_ack latency in edges", n, 2);
      data   = reg_rdata;
      reg_cs = 1'b0;                             // Drop cs after ack
      reg_wr = 1'b0;
      @(posedge mclk);
      #1;
      check_val("reg_ack", {31'h0, reg_ack}, 32'h0);   // Pulse is one cycle
      @(posedge mclk);                           // Second idle cycle
      #1;
   endtask

   task automatic bus_write(input logic [4:0] idx, input reg_word_t wd, input logic [3:0] be);
      reg_word_t dummy;
      bus_xfer(1'b1, idx, wd, be, dummy);
   endtask

   task automatic read_expect(input logic [4:0] idx, input reg_word_t exp);
      reg_word_t data;
      bus_xfer(1'b0, idx, 32'h0, 4'hf, data);
      check_val($sformatf("reg_rdata at index %0d", idx), data, exp);
   endtask

   //----------------------------------------
   // Stimulus
   //----------------------------------------
   initial
   begin
      reg_word_t  wd;
      reg_word_t  ev;
      reg_word_t  exp;
      logic [3:0] be;
      logic [4:0] idx;
      err_cnt        = 0;
      tmo_cnt        = 0;
      seed           = 32'hf8bf;
      h_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = 8'h0;
      reg_wdata      = 32'h0;
      reg_be         = 4'h0;
      ext_intr_in    = 2'b00;
      gpio_in_data   = 32'h0;
      gpio_int_event = 32'h0;
      stat           = 32'h0;
      for (int i = 0; i < 32; i++)
         shadow[i] = 32'h0;
      exp_id.f.manu_id = 16'h8949;
      exp_id.f.part_id = 8'h02;
      exp_id.f.rev_id  = 8'h01;
      shadow[`PINMUX_R_CHIP_ID] = exp_id.raw;
      shadow[`PINMUX_R_FUSE]    = 32'hA55A_A55A;
      repeat (10) @(posedge mclk);
      #1;
      h_reset_n = 1'b1;

      // Reset values, dropped slots included
      for (int i = 0; i <= 16; i++)
         read_expect(5'(i), shadow[i]);

      // Random byte-enable writes, then read back
      for (int r = 0; r < 2; r++)
      begin
         for (int k = 0; k < 9; k++)
         begin
            idx = WR_IDX[k];
            wd  = $random(seed);
            be  = 4'($random(seed));
            exp = ((shadow[idx] & ~lane_mask(be)) | (wd & lane_mask(be))) & width_mask(idx);
            bus_write(idx, wd, be);
            shadow[idx] = exp;
            read_expect(idx, exp);
            check_cfg(idx, exp);
         end
      end

      // Input synchronizer, two and three edges
      for (int k = 0; k < 4; k++)
      begin
         exp = gpio_in_data;                     // Settled old value
         wd  = $random(seed);
         gpio_in_data = wd;
         @(posedge mclk);
         #1;
         check_val("gpio_prev_indata", gpio_prev_indata, exp);
         @(posedge mclk);
         #1;
         check_val("gpio_prev_indata", gpio_prev_indata, wd);
         check_val("cfg_gpio_data_in", cfg_gpio_data_in, exp);
         @(posedge mclk);
         #1;
         check_val("cfg_gpio_data_in", cfg_gpio_data_in, wd);
         read_expect(`PINMUX_R_GPIO_IN, wd);
      end

      //----------------------------------------
      // Interrupt status
      //----------------------------------------
      ev = $random(seed);
      gpio_int_event = ev;                       // Single-cycle event
      @(posedge mclk);
      #1;
      gpio_int_event = 32'h0;
      stat = ev;
      read_expect(`PINMUX_R_INT_STAT, stat);
      read_expect(`PINMUX_R_INT_SET, stat);      // Same word at both indices
      for (int k = 0; k < 3; k++)
      begin
         wd = $random(seed);
         be = 4'($random(seed));
         bus_write(`PINMUX_R_INT_STAT, wd, be);  // W1C
         stat = stat & ~(wd & lane_mask(be));
         read_expect(`PINMUX_R_INT_STAT, stat);
         wd = $random(seed);
         be = 4'($random(seed));
         bus_write(`PINMUX_R_INT_SET, wd, be);   // W1S
         stat = stat | (wd & lane_mask(be));
         read_expect(`PINMUX_R_INT_STAT, stat);
      end
      // Event only in the two clear cycles of a full clear
      ev = 32'h0100_0010;
      fork
         bus_write(`PINMUX_R_INT_STAT, 32'hffff_ffff, 4'hf);
         begin
            @(posedge mclk);                     // Request captured here
            #1;
            gpio_int_event = ev;
            repeat (2) @(posedge mclk);          // Both clear edges
            #1;
            gpio_int_event = 32'h0;
         end
      join
      stat = ev;
      read_expect(`PINMUX_R_INT_STAT, stat);

      // Summary IRQ tracks the mask
      for (int k = 0; k < 5; k++)
      begin
         wd = (k == 0) ? 32'h0 : (k == 1) ? stat : $random(seed);
         bus_write(`PINMUX_R_INT_MASK, wd, 4'hf);
         check_val("user_irq[2]", {31'h0, user_irq[2]}, {31'h0, |(stat & wd)});
      end
      for (int k = 0; k < 4; k++)
      begin
         ext_intr_in = 2'(k);                    // Pins pass straight through
         @(posedge mclk);
         #1;
         check_val("user_irq[1:0]", {30'h0, user_irq[1:0]}, {30'h0, 2'(k)});
      end

      $display("Errors: %0d failed checks, %0d timeouts", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== verilog/pinmux_reg.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

module pinmux_reg import pinmux_pkg::*; (
   input  logic                       mclk,
   input  logic                       h_reset_n,

   // Register bus
   input  logic                       reg_cs,
   input  logic                       reg_wr,
   input  logic [`PINMUX_AW-1:0]      reg_addr,
   input  logic [`PINMUX_DW-1:0]      reg_wdata,
   input  logic [`PINMUX_BE_W-1:0]    reg_be,
   output logic [`PINMUX_DW-1:0]      reg_rdata,
   output logic                       reg_ack,

   input  logic [1:0]                 ext_intr_in,

   // RISC configuration
   output logic [`PINMUX_DW-1:0]      fuse_mhartid,
   output logic [`PINMUX_IRQ_W-1:0]   irq_lines,
   output logic [2:0]                 user_irq,
   output logic [`PINMUX_PULSE_W-1:0] cfg_pulse_1us,

   // GPIO
   input  logic [`PINMUX_DW-1:0]      gpio_in_data,
   input  logic [`PINMUX_DW-1:0]      gpio_int_event,
   output logic [`PINMUX_DW-1:0]      cfg_gpio_out_data,
   output logic [`PINMUX_DW-1:0]      cfg_gpio_data_in,
   output logic [`PINMUX_DW-1:0]      cfg_gpio_dir_sel,
   output logic [`PINMUX_DW-1:0]      cfg_gpio_out_type,
   output logic [`PINMUX_DW-1:0]      cfg_gpio_posedge_int_sel,
   output logic [`PINMUX_DW-1:0]      cfg_gpio_negedge_int_sel,
   output logic [`PINMUX_DW-1:0]      gpio_prev_indata
);

   reg_word_t risc_rdata;       // Read words, ORed in the front end
   reg_word_t gpio_cfg_rdata;
   reg_word_t gpio_int_rdata;
   logic      gpio_intr;        // Status & mask summary

   reg_bus_if u_bus ();

   //----------------------------------------
   // Bus front end
   //----------------------------------------
   reg_bus_front u_front (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .cs             (reg_cs),
      .wr             (reg_wr),
      .addr           (reg_addr),
      .wdata          (reg_wdata),
      .be             (reg_be),
      .risc_rdata     (risc_rdata),
      .gpio_cfg_rdata (gpio_cfg_rdata),
      .gpio_int_rdata (gpio_int_rdata),
      .rdata          (reg_rdata),
      .ack            (reg_ack),
      .bus            (u_bus)
   );

   risc_cfg_regs u_risc (
      .mclk          (mclk),
      .h_reset_n     (h_reset_n),
      .ext_intr_in   (ext_intr_in),
      .gpio_intr     (gpio_intr),
      .bus           (u_bus),
      .rdata         (risc_rdata),
      .fuse_mhartid  (fuse_mhartid),
      .irq_lines     (irq_lines),
      .user_irq      (user_irq),
      .cfg_pulse_1us (cfg_pulse_1us)
   );

   gpio_cfg_regs u_gpio_cfg (
      .mclk                     (mclk),
      .h_reset_n                (h_reset_n),
      .bus                      (u_bus),
      .rdata                    (gpio_cfg_rdata),
      .cfg_gpio_out_data        (cfg_gpio_out_data),
      .cfg_gpio_dir_sel         (cfg_gpio_dir_sel),
      .cfg_gpio_out_type        (cfg_gpio_out_type),
      .cfg_gpio_posedge_int_sel (cfg_gpio_posedge_int_sel),
      .cfg_gpio_negedge_int_sel (cfg_gpio_negedge_int_sel)
   );

   gpio_intr_ctrl u_gpio_int (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .gpio_in_data     (gpio_in_data),
      .gpio_int_event   (gpio_int_event),
      .bus              (u_bus),
      .rdata            (gpio_int_rdata),
      .cfg_gpio_data_in (cfg_gpio_data_in),
      .gpio_prev_indata (gpio_prev_indata),
      .gpio_intr        (gpio_intr)
   );

endmodule

// ==== verilog/gpio_intr_ctrl.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

module gpio_intr_ctrl import pinmux_pkg::*; (
   input  logic      mclk,
   input  logic      h_reset_n,
   input  reg_word_t gpio_in_data,      // Raw pad inputs
   input  reg_word_t gpio_int_event,    // Edge events from GPIO control

   reg_bus_if.regs   bus,

   output reg_word_t rdata,
   output reg_word_t cfg_gpio_data_in,  // Third stage, history
   output reg_word_t gpio_prev_indata,  // Second stage, synchronized
   output logic      gpio_intr          // Masked summary
);

   reg_word_t in_s;        // First sync stage
   reg_word_t in_ss;       // Second sync stage
   reg_word_t int_stat;    // Interrupt status
   reg_word_t int_mask;    // Interrupt enable mask
   reg_word_t stat_nxt;
   logic      clr_hit;
   logic      set_hit;
   logic      mask_hit;

   //----------------------------------------
   // Input synchronizer
   //----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         in_s             <= '0;
         in_ss            <= '0;
         cfg_gpio_data_in <= '0;
      end
      else
      begin
         in_s             <= gpio_in_data;
         in_ss            <= in_s;
         cfg_gpio_data_in <= in_ss;    // Previous sample for edge compare
      end
   end

   assign gpio_prev_indata = in_ss;

   //----------------------------------------
   // Interrupt status
   //----------------------------------------
   assign clr_hit  = bus.wr_en && (bus.idx == `PINMUX_R_INT_STAT);
   assign set_hit  = bus.wr_en && (bus.idx == `PINMUX_R_INT_SET);
   assign mask_hit = bus.wr_en && (bus.idx == `PINMUX_R_INT_MASK);

   always_comb
   begin
      stat_nxt = int_stat;
      for (int i = 0; i < `PINMUX_BE_W; i++)
      begin
         if (clr_hit && bus.be[i])
            stat_nxt[i*8 +: 8] = int_stat[i*8 +: 8] & ~bus.wdata[i*8 +: 8];  // W1C
         else if (set_hit && bus.be[i])
            stat_nxt[i*8 +: 8] = int_stat[i*8 +: 8] | bus.wdata[i*8 +: 8];   // W1S
      end
      // Hardware events override a same-cycle clear
      stat_nxt = stat_nxt | gpio_int_event;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         int_stat <= '0;
         int_mask <= '0;
      end
      else
      begin
         int_stat <= stat_nxt;                 // Updated every cycle
         if (mask_hit)
            int_mask <= bus.be_merge(int_mask);
      end
   end

   // Summary to user_irq[2]
   assign gpio_intr = |(int_stat & int_mask);

   // Set index reads back the status too
   always_comb
   begin
      case (bus.idx)
         `PINMUX_R_GPIO_IN  : rdata = cfg_gpio_data_in;
         `PINMUX_R_INT_STAT : rdata = int_stat;
         `PINMUX_R_INT_SET  : rdata = int_stat;
         `PINMUX_R_INT_MASK : rdata = int_mask;
         default            : rdata = '0;
      endcase
   end

endmodule

// ==== verilog/gpio_cfg_regs.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

module gpio_cfg_regs import pinmux_pkg::*; (
   input  logic      mclk,
   input  logic      h_reset_n,

   reg_bus_if.regs   bus,

   output reg_word_t rdata,
   output reg_word_t cfg_gpio_out_data,         // Pin output levels
   output reg_word_t cfg_gpio_dir_sel,          // Pad direction per pin
   output reg_word_t cfg_gpio_out_type,         // 0 static, 1 waveform
   output reg_word_t cfg_gpio_posedge_int_sel,  // Rising edge IRQ enable
   output reg_word_t cfg_gpio_negedge_int_sel   // Falling edge IRQ enable
);

   logic wr_out;
   logic wr_dir;
   logic wr_type;
   logic wr_pos;
   logic wr_neg;

   // Write strobes per index
   assign wr_out  = bus.wr_en && (bus.idx == `PINMUX_R_GPIO_OUT);
   assign wr_dir  = bus.wr_en && (bus.idx == `PINMUX_R_GPIO_DIR);
   assign wr_type = bus.wr_en && (bus.idx == `PINMUX_R_GPIO_TYPE);
   assign wr_pos  = bus.wr_en && (bus.idx == `PINMUX_R_POSEDGE);
   assign wr_neg  = bus.wr_en && (bus.idx == `PINMUX_R_NEGEDGE);

   //----------------------------------------
   // Configuration registers
   //----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         cfg_gpio_out_data        <= '0;
         cfg_gpio_dir_sel         <= '0;
         cfg_gpio_out_type        <= '0;
         cfg_gpio_posedge_int_sel <= '0;
         cfg_gpio_negedge_int_sel <= '0;
      end
      else
      begin
         if (wr_out)
            cfg_gpio_out_data <= bus.be_merge(cfg_gpio_out_data);
         if (wr_dir)
            cfg_gpio_dir_sel <= bus.be_merge(cfg_gpio_dir_sel);
         if (wr_type)
            cfg_gpio_out_type <= bus.be_merge(cfg_gpio_out_type);
         if (wr_pos)
            cfg_gpio_posedge_int_sel <= bus.be_merge(cfg_gpio_posedge_int_sel);
         if (wr_neg)
            cfg_gpio_negedge_int_sel <= bus.be_merge(cfg_gpio_negedge_int_sel);
      end
   end

   // Read word, zero off these indices
   always_comb
   begin
      case (bus.idx)
         `PINMUX_R_GPIO_OUT  : rdata = cfg_gpio_out_data;
         `PINMUX_R_GPIO_DIR  : rdata = cfg_gpio_dir_sel;
         `PINMUX_R_GPIO_TYPE : rdata = cfg_gpio_out_type;
         `PINMUX_R_POSEDGE   : rdata = cfg_gpio_posedge_int_sel;
         `PINMUX_R_NEGEDGE   : rdata = cfg_gpio_negedge_int_sel;
         default             : rdata = '0;
      endcase
   end

endmodule

// ==== verilog/risc_cfg_regs.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

module risc_cfg_regs import pinmux_pkg::*; (
   input  logic                       mclk,
   input  logic                       h_reset_n,
   input  logic [1:0]                 ext_intr_in,   // External IRQ pins
   input  logic                       gpio_intr,     // GPIO summary IRQ

   reg_bus_if.regs                    bus,

   output reg_word_t                  rdata,
   output reg_word_t                  fuse_mhartid,
   output logic [`PINMUX_IRQ_W-1:0]   irq_lines,
   output logic [2:0]                 user_irq,
   output logic [`PINMUX_PULSE_W-1:0] cfg_pulse_1us
);

   chip_id_t  chip_id;
   reg_word_t irq_word;     // IRQ lines zero-extended
   reg_word_t pulse_word;   // Pulse divider zero-extended
   reg_word_t irq_nxt;
   reg_word_t pulse_nxt;

   // Fixed identity word
   assign chip_id.f.manu_id = `PINMUX_MANU_ID;
   assign chip_id.f.part_id = `PINMUX_PART_ID;
   assign chip_id.f.rev_id  = `PINMUX_REV_ID;

   assign irq_word   = {{(`PINMUX_DW-`PINMUX_IRQ_W){1'b0}}, irq_lines};
   assign pulse_word = {{(`PINMUX_DW-`PINMUX_PULSE_W){1'b0}}, cfg_pulse_1us};
   assign irq_nxt    = bus.be_merge(irq_word);
   assign pulse_nxt  = bus.be_merge(pulse_word);

   //----------------------------------------
   // Writable registers
   //----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         fuse_mhartid  <= `PINMUX_FUSE_RST;
         irq_lines     <= '0;
         cfg_pulse_1us <= '0;
      end
      else if (bus.wr_en)
      begin
         if (bus.idx == `PINMUX_R_FUSE)
            fuse_mhartid <= bus.be_merge(fuse_mhartid);
         if (bus.idx == `PINMUX_R_IRQ)
            irq_lines <= irq_nxt[`PINMUX_IRQ_W-1:0];           // Upper lanes dropped
         if (bus.idx == `PINMUX_R_PULSE)
            cfg_pulse_1us <= pulse_nxt[`PINMUX_PULSE_W-1:0];
      end
   end

   // GPIO summary on top of the two pins
   assign user_irq = {gpio_intr, ext_intr_in};

   // Read word for this block
   always_comb
   begin
      case (bus.idx)
         `PINMUX_R_CHIP_ID : rdata = chip_id.raw;
         `PINMUX_R_FUSE    : rdata = fuse_mhartid;
         `PINMUX_R_IRQ     : rdata = irq_word;
         `PINMUX_R_PULSE   : rdata = pulse_word;
         default           : rdata = '0;
      endcase
   end

endmodule

// ==== verilog/reg_bus_front.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

module reg_bus_front import pinmux_pkg::*; (
   input  logic                   mclk,
   input  logic                   h_reset_n,

   // External request
   input  logic                   cs,
   input  logic                   wr,
   input  logic [`PINMUX_AW-1:0]  addr,
   input  reg_word_t              wdata,
   input  logic [`PINMUX_BE_W-1:0] be,

   // Read words from the register blocks
   input  reg_word_t              risc_rdata,
   input  reg_word_t              gpio_cfg_rdata,
   input  reg_word_t              gpio_int_rdata,

   output reg_word_t              rdata,
   output logic                   ack,

   reg_bus_if.front               bus
);

   logic      rd_en;     // Registered cs & !wr
   logic      cs_l;      // cs one edge late
   logic      cs_2l;     // cs two edges late
   reg_word_t rd_merge;

   //----------------------------------------
   // Request capture
   //----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         rd_en     <= 1'b0;
         bus.wr_en <= 1'b0;
         cs_l      <= 1'b0;
         cs_2l     <= 1'b0;
      end
      else
      begin
         rd_en     <= cs & ~wr;
         bus.wr_en <= cs & wr;
         cs_l      <= cs;
         cs_2l     <= cs_l;
      end
   end

   // Payload follows the pins every cycle
   always_ff @(posedge mclk)
   begin
      bus.idx   <= addr[`PINMUX_IDX_LSB +: `PINMUX_IDX_W];
      bus.wdata <= wdata;
      bus.be    <= be;
   end

   // Blocks return zero off their own indices
   assign rd_merge = risc_rdata | gpio_cfg_rdata | gpio_int_rdata;

   //----------------------------------------
   // Acknowledge and read data
   //----------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         rdata <= '0;
         ack   <= 1'b0;
      end
      else if ((rd_en | bus.wr_en) && !ack && !cs_2l)  // First cycle of a request only
      begin
         if (rd_en)
            rdata <= rd_merge;                         // Capture on reads
         ack <= 1'b1;
      end
      else
         ack <= 1'b0;                                  // One-cycle pulse
   end

endmodule

// ==== verilog/reg_bus_if.sv ====
`timescale 1ns/1ps
`include "pinmux_defs.svh"

interface reg_bus_if import pinmux_pkg::*; ();

   logic                     wr_en;   // Registered cs & wr
   logic [`PINMUX_IDX_W-1:0] idx;     // Registered word index
   reg_word_t                wdata;   // Registered write data
   logic [`PINMUX_BE_W-1:0]  be;      // Registered byte enables

   // Current value with the enabled byte lanes replaced by wdata
   function automatic reg_word_t be_merge(input reg_word_t cur);
      reg_word_t nxt;
      nxt = cur;
      for (int i = 0; i < `PINMUX_BE_W; i++)
      begin
         if (be[i])
            nxt[i*8 +: 8] = wdata[i*8 +: 8];
      end
      return nxt;
   endfunction

   // Front end drives the request
   modport front (output wr_en, idx, wdata, be);

   // Register blocks decode it
   modport regs (input wr_en, idx, wdata, be, import be_merge);

endinterface

// ==== verilog/pinmux_pkg.sv ====
`include "pinmux_defs.svh"

package pinmux_pkg;

   // One bus word
   typedef logic [`PINMUX_DW-1:0] reg_word_t;

   //----------------------------------------
   // Chip ID word layout
   //----------------------------------------
   typedef struct packed
   {
      logic [15:0] manu_id;   // Manufacturer code
      logic [7:0]  part_id;   // Part number
      logic [7:0]  rev_id;    // Silicon revision
   } chip_id_fields_t;

   // Same 32 bits seen raw or by field
   typedef union packed
   {
      reg_word_t       raw;
      chip_id_fields_t f;
   } chip_id_t;

endpackage

// ==== verilog/pinmux_defs.svh ====
`ifndef PINMUX_DEFS_SVH
`define PINMUX_DEFS_SVH

// Register bus geometry
`define PINMUX_DW          32            // Data word width
`define PINMUX_BE_W        4             // One enable per byte lane
`define PINMUX_AW          8             // External byte address
`define PINMUX_IDX_W       5             // Word index width
`define PINMUX_IDX_LSB     2             // Index starts at addr[2]

// Word index map, gaps read as zero
`define PINMUX_R_CHIP_ID   5'd0
`define PINMUX_R_FUSE      5'd1
`define PINMUX_R_GPIO_IN   5'd2
`define PINMUX_R_GPIO_OUT  5'd3
`define PINMUX_R_GPIO_DIR  5'd4
`define PINMUX_R_GPIO_TYPE 5'd5
`define PINMUX_R_IRQ       5'd6
`define PINMUX_R_PULSE     5'd7
`define PINMUX_R_INT_STAT  5'd9          // Write one to clear
`define PINMUX_R_INT_SET   5'd10         // Write one to set
`define PINMUX_R_INT_MASK  5'd11
`define PINMUX_R_POSEDGE   5'd12
`define PINMUX_R_NEGEDGE   5'd13

// Reset values and identity
`define PINMUX_FUSE_RST    32'hA55A_A55A
`define PINMUX_MANU_ID     16'h8949
`define PINMUX_PART_ID     8'h02
`define PINMUX_REV_ID      8'h01

// Narrow register fields
`define PINMUX_IRQ_W       16
`define PINMUX_PULSE_W     10

`endif
